// File: hdl/tcdm_dma_pkg.sv
/*
 * Shared definitions of the TCDM DMA command path
 *  - Address, length, stream ID and bank word widths
 *  - DMA opcode encoding
 *  - Command, beat, Wishbone request/response and read response structs
 */

package tcdm_dma_pkg;

   // TCDM byte address and bank word widths
   localparam int ADDR_WIDTH = 12;
   localparam int DATA_WIDTH = 32;

   // Length field holds byte count minus one
   localparam int LEN_WIDTH  = 15;
   localparam int SID_WIDTH  = 2;

   typedef enum logic
   {
      DMA_READ  = 1'b0,
      DMA_WRITE = 1'b1
   } dma_opc_e;

   // Command as pushed by the outside controller
   typedef struct packed
   {
      dma_opc_e               opc;
      logic [LEN_WIDTH-1:0]   len;
      logic [ADDR_WIDTH-1:0]  add;
      logic [SID_WIDTH-1:0]   sid;
      logic [DATA_WIDTH-1:0]  fill;
   } dma_cmd_t;

   // One aligned 8-byte beat with the low three add bits at zero
   typedef struct packed
   {
      dma_opc_e               opc;
      logic [ADDR_WIDTH-1:0]  add;
      logic [SID_WIDTH-1:0]   sid;
      logic                   eop;
      logic [DATA_WIDTH-1:0]  fill;
   } tcdm_beat_t;

   // Wishbone classic master side of one bank
   typedef struct packed
   {
      logic                     cyc;
      logic                     stb;
      logic                     we;
      logic [ADDR_WIDTH-1:0]    adr;
      logic [DATA_WIDTH-1:0]    dat;
      logic [DATA_WIDTH/8-1:0]  sel;
   } wb_req_t;

   typedef struct packed
   {
      logic                   ack;
      logic [DATA_WIDTH-1:0]  dat;
   } wb_rsp_t;

   // Read beat result with the high word from bank 1
   typedef struct packed
   {
      logic [2*DATA_WIDTH-1:0]  data;
      logic [SID_WIDTH-1:0]     sid;
      logic                     eop;
   } tcdm_rsp_t;

endpackage

// File: hdl/dma_cmd_queue.sv
/*
 * DMA command queue
 *  - Circular buffer of CMD_QUEUE_DEPTH commands
 *  - req/gnt handshake on the push and the pop side
 *  - Simultaneous push and pop
 */

module dma_cmd_queue
#(
   parameter int unsigned CMD_QUEUE_DEPTH = 4
)
(
   input  logic                   clk_i,
   input  logic                   rst_ni,

   input  tcdm_dma_pkg::dma_cmd_t cmd_i,
   input  logic                   cmd_req_i,
   output logic                   cmd_gnt_o,

   output tcdm_dma_pkg::dma_cmd_t cmd_o,
   output logic                   cmd_req_o,
   input  logic                   cmd_gnt_i
);
   import tcdm_dma_pkg::*;

   localparam int unsigned PTR_WIDTH = $clog2(CMD_QUEUE_DEPTH);

   // Command storage
   dma_cmd_t mem_q [CMD_QUEUE_DEPTH];

   // Extra MSB on pointers tells full from empty
   logic [PTR_WIDTH:0] wr_ptr_q;
   logic [PTR_WIDTH:0] rd_ptr_q;
   logic               full;
   logic               empty;
   logic               push;
   logic               pop;

   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full  = (wr_ptr_q[PTR_WIDTH] != rd_ptr_q[PTR_WIDTH]) &&
                  (wr_ptr_q[PTR_WIDTH-1:0] == rd_ptr_q[PTR_WIDTH-1:0]);

   // Grant follows free space alone and ignores the request
   assign cmd_gnt_o = ~full;
   assign cmd_req_o = ~empty;
   assign push      = cmd_req_i & cmd_gnt_o;
   assign pop       = cmd_req_o & cmd_gnt_i;

   // Head of the queue
   assign cmd_o = mem_q[rd_ptr_q[PTR_WIDTH-1:0]];

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_q[wr_ptr_q[PTR_WIDTH-1:0]] <= cmd_i;
   end

endmodule

// File: hdl/tcdm_cmd_unpack.sv
/*
 * Command unpacker
 *  - Splits a DMA command into aligned 8-byte beats
 *  - Two-state FSM, first beat issued in the accept cycle
 *  - Beat counter sets end-of-transfer on the last beat
 */

module tcdm_cmd_unpack
(
   input  logic                     clk_i,
   input  logic                     rst_ni,

   input  tcdm_dma_pkg::dma_cmd_t   cmd_i,
   input  logic                     cmd_req_i,
   output logic                     cmd_gnt_o,

   output tcdm_dma_pkg::tcdm_beat_t beat_o,
   output logic                     beat_req_o,
   input  logic                     beat_gnt_i
);
   import tcdm_dma_pkg::*;

   // Wide enough for the beat index of the longest command
   localparam int CNT_WIDTH = LEN_WIDTH - 2;

   typedef enum logic
   {
      ST_IDLE,
      ST_RUN
   } state_e;

   state_e                state_q;
   state_e                state_d;

   // Beat count of the incoming command minus one
   logic [LEN_WIDTH:0]    span;
   logic [CNT_WIDTH-1:0]  beats_extra;

   // Control registers of the running command
   logic [CNT_WIDTH-1:0]  nb_q;
   logic [CNT_WIDTH-1:0]  cnt_q;

   // Payload of the running command
   logic [ADDR_WIDTH-1:0] add_q;
   dma_opc_e              opc_q;
   logic [SID_WIDTH-1:0]  sid_q;
   logic [DATA_WIDTH-1:0] fill_q;

   logic                  cmd_hs;
   logic                  beat_hs;

   //****************************************
   // Beat count
   //****************************************

   // Offset in first block plus length gives the last block index
   assign span        = {1'b0, cmd_i.len} + {{(LEN_WIDTH-2){1'b0}}, cmd_i.add[2:0]};
   assign beats_extra = span[LEN_WIDTH:3];

   assign cmd_hs  = cmd_req_i & cmd_gnt_o;
   assign beat_hs = beat_req_o & beat_gnt_i;

   //****************************************
   // FSM
   //****************************************

   always_comb
   begin
      state_d     = state_q;
      cmd_gnt_o   = 1'b0;
      beat_req_o  = 1'b0;
      beat_o.opc  = opc_q;
      beat_o.add  = add_q;
      beat_o.sid  = sid_q;
      beat_o.fill = fill_q;
      beat_o.eop  = 1'b0;

      case (state_q)
         ST_IDLE:
         begin
            // First beat straight from the queue head
            cmd_gnt_o   = beat_gnt_i;
            beat_req_o  = cmd_req_i;
            beat_o.opc  = cmd_i.opc;
            beat_o.add  = {cmd_i.add[ADDR_WIDTH-1:3], 3'b000};
            beat_o.sid  = cmd_i.sid;
            beat_o.fill = cmd_i.fill;
            // Single-beat command ends here
            beat_o.eop  = (beats_extra == '0);
            if (cmd_hs && (beats_extra != '0))
               state_d = ST_RUN;
         end

         ST_RUN:
         begin
            beat_req_o = 1'b1;
            beat_o.eop = (cnt_q == nb_q);
            if (beat_gnt_i && beat_o.eop)
               state_d = ST_IDLE;
         end

         default:
            state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= ST_IDLE;
         nb_q    <= '0;
         cnt_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         // Beat 0 goes out with the accept
         if (cmd_hs)
         begin
            nb_q  <= beats_extra;
            cnt_q <= CNT_WIDTH'(1);
         end
         else if (beat_hs)
            cnt_q <= cnt_q + 1'b1;
      end
   end

   // Next beat address steps by one bank pair
   always_ff @(posedge clk_i)
   begin
      if (cmd_hs)
      begin
         opc_q  <= cmd_i.opc;
         sid_q  <= cmd_i.sid;
         fill_q <= cmd_i.fill;
         add_q  <= {cmd_i.add[ADDR_WIDTH-1:3], 3'b000} + ADDR_WIDTH'(8);
      end
      else if (beat_hs)
         add_q <= add_q + ADDR_WIDTH'(8);
   end

endmodule

// File: hdl/tcdm_bank_master.sv
/*
 * Bank master
 *  - Holds one beat, runs two Wishbone classic cycles in parallel
 *  - Bank 0 at the beat base, bank 1 at base+4
 *  - Per-bank done flags, read acks forwarded with sid and eop
 */

module tcdm_bank_master
(
   input  logic                                     clk_i,
   input  logic                                     rst_ni,

   input  tcdm_dma_pkg::tcdm_beat_t                 beat_i,
   input  logic                                     beat_req_i,
   output logic                                     beat_gnt_o,

   output tcdm_dma_pkg::wb_req_t [1:0]              wb_req_o,
   input  tcdm_dma_pkg::wb_rsp_t [1:0]              wb_rsp_i,

   output logic [1:0]                               rd_ack_o,
   output logic [1:0][tcdm_dma_pkg::DATA_WIDTH-1:0] rd_data_o,
   output logic [tcdm_dma_pkg::SID_WIDTH-1:0]       rd_sid_o,
   output logic                                     rd_eop_o
);
   import tcdm_dma_pkg::*;

   tcdm_beat_t beat_q;
   logic       busy_q;
   logic [1:0] done_q;

   // Bank still waiting for its ack
   logic [1:0] active;
   logic [1:0] ack;
   logic       beat_done;

   // Free only when no beat is held
   assign beat_gnt_o = ~busy_q;

   // Later ack closes the beat
   assign beat_done = busy_q & (&(done_q | ack));

   for (genvar b = 0; b < 2; b++)
   begin : gen_bank
      assign active[b] = busy_q & ~done_q[b];
      assign ack[b]    = active[b] & wb_rsp_i[b].ack;

      // cyc and stb held together until this bank acks
      assign wb_req_o[b].cyc = active[b];
      assign wb_req_o[b].stb = active[b];
      assign wb_req_o[b].we  = (beat_q.opc == DMA_WRITE);
      assign wb_req_o[b].adr = beat_q.add + ADDR_WIDTH'(4 * b);
      assign wb_req_o[b].dat = beat_q.fill;
      assign wb_req_o[b].sel = '1;

      assign rd_ack_o[b]  = ack[b] & (beat_q.opc == DMA_READ);
      assign rd_data_o[b] = wb_rsp_i[b].dat;
   end

   assign rd_sid_o = beat_q.sid;
   assign rd_eop_o = beat_q.eop;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         busy_q <= 1'b0;
         done_q <= '0;
      end
      else if (beat_req_i && beat_gnt_o)
      begin
         busy_q <= 1'b1;
         done_q <= '0;
      end
      else if (beat_done)
         busy_q <= 1'b0;
      else
         done_q <= done_q | ack;
   end

   always_ff @(posedge clk_i)
   begin
      if (beat_req_i && beat_gnt_o)
         beat_q <= beat_i;
   end

endmodule

// File: hdl/tcdm_rsp_collect.sv
/*
 * Read response collector
 *  - Captures the two bank words of a read beat
 *  - Emits one 64-bit response with sid and eop per beat
 */

module tcdm_rsp_collect
(
   input  logic                                     clk_i,
   input  logic                                     rst_ni,

   input  logic [1:0]                               rd_ack_i,
   input  logic [1:0][tcdm_dma_pkg::DATA_WIDTH-1:0] rd_data_i,
   input  logic [tcdm_dma_pkg::SID_WIDTH-1:0]       rd_sid_i,
   input  logic                                     rd_eop_i,

   output tcdm_dma_pkg::tcdm_rsp_t                  rsp_o,
   output logic                                     rsp_valid_o
);
   import tcdm_dma_pkg::*;

   logic [1:0]                 have_q;
   logic [1:0][DATA_WIDTH-1:0] word_q;
   logic [1:0][DATA_WIDTH-1:0] word;
   logic                       both;

   // Word arriving now wins over the stored one
   for (genvar b = 0; b < 2; b++)
   begin : gen_word
      assign word[b] = rd_ack_i[b] ? rd_data_i[b] : word_q[b];
   end

   assign both = &(have_q | rd_ack_i);

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         have_q      <= '0;
         rsp_valid_o <= 1'b0;
      end
      else
      begin
         have_q      <= both ? 2'b00 : (have_q | rd_ack_i);
         rsp_valid_o <= both;
      end
   end

   always_ff @(posedge clk_i)
   begin
      word_q <= word;
      // Bank 1 lands in the high word
      if (both)
      begin
         rsp_o.data <= word;
         rsp_o.sid  <= rd_sid_i;
         rsp_o.eop  <= rd_eop_i;
      end
   end

endmodule

// File: hdl/tcdm_dma_top.sv
/*
 * TCDM DMA command path top
 *  - Command queue, beat unpacker, bank master, response collector
 *  - Sets the command queue depth
 */

module tcdm_dma_top
#(
   parameter int unsigned CMD_QUEUE_DEPTH = 4
)
(
   input  logic                        clk_i,
   input  logic                        rst_ni,

   input  tcdm_dma_pkg::dma_cmd_t      cmd_i,
   input  logic                        cmd_req_i,
   output logic                        cmd_gnt_o,

   output tcdm_dma_pkg::wb_req_t [1:0] wb_req_o,
   input  tcdm_dma_pkg::wb_rsp_t [1:0] wb_rsp_i,

   output tcdm_dma_pkg::tcdm_rsp_t     rsp_o,
   output logic                        rsp_valid_o
);
   import tcdm_dma_pkg::*;

   // Queue head toward the unpacker
   dma_cmd_t                   q_cmd;
   logic                       q_req;
   logic                       q_gnt;

   // Beat handshake
   tcdm_beat_t                 beat;
   logic                       beat_req;
   logic                       beat_gnt;

   // Read words of a beat
   logic [1:0]                 rd_ack;
   logic [1:0][DATA_WIDTH-1:0] rd_data;
   logic [SID_WIDTH-1:0]       rd_sid;
   logic                       rd_eop;

   dma_cmd_queue
   #(
      .CMD_QUEUE_DEPTH ( CMD_QUEUE_DEPTH )
   )
   u_cmd_queue
   (
      .clk_i, .rst_ni,
      .cmd_i, .cmd_req_i, .cmd_gnt_o,
      .cmd_o     ( q_cmd ),
      .cmd_req_o ( q_req ),
      .cmd_gnt_i ( q_gnt )
   );

   tcdm_cmd_unpack u_cmd_unpack
   (
      .clk_i, .rst_ni,
      .cmd_i      ( q_cmd    ),
      .cmd_req_i  ( q_req    ),
      .cmd_gnt_o  ( q_gnt    ),
      .beat_o     ( beat     ),
      .beat_req_o ( beat_req ),
      .beat_gnt_i ( beat_gnt )
   );

   tcdm_bank_master u_bank_master
   (
      .clk_i, .rst_ni,
      .beat_i     ( beat     ),
      .beat_req_i ( beat_req ),
      .beat_gnt_o ( beat_gnt ),
      .wb_req_o, .wb_rsp_i,
      .rd_ack_o   ( rd_ack   ),
      .rd_data_o  ( rd_data  ),
      .rd_sid_o   ( rd_sid   ),
      .rd_eop_o   ( rd_eop   )
   );

   tcdm_rsp_collect u_rsp_collect
   (
      .clk_i, .rst_ni,
      .rd_ack_i  ( rd_ack  ),
      .rd_data_i ( rd_data ),
      .rd_sid_i  ( rd_sid  ),
      .rd_eop_i  ( rd_eop  ),
      .rsp_o, .rsp_valid_o
   );

endmodule

// File: verification/tcdm_bank_model.sv
/*
 * Two-bank Wishbone classic memory model
 *  - 512 words per bank, preloaded with an address pattern
 *  - Registered ack after a per-bank wait chosen by the testbench
 *  - Write reports toward the reference model
 */

module tcdm_bank_model
(
   input  logic                                     clk_i,
   input  logic                                     rst_ni,

   input  tcdm_dma_pkg::wb_req_t [1:0]              wb_req_i,
   output tcdm_dma_pkg::wb_rsp_t [1:0]              wb_rsp_o,

   input  logic [1:0][3:0]                          delay_i,

   output logic [1:0]                               wr_o,
   output logic [1:0][tcdm_dma_pkg::ADDR_WIDTH-1:0] wr_adr_o,
   output logic [1:0][tcdm_dma_pkg::DATA_WIDTH-1:0] wr_dat_o
);
   import tcdm_dma_pkg::*;

   for (genvar b = 0; b < 2; b++)
   begin : gen_bank
      logic [DATA_WIDTH-1:0] mem [512];
      logic [3:0]            wait_q;
      logic                  ack_q;
      logic                  wr_q;
      logic [DATA_WIDTH-1:0] rdat_q;
      logic [ADDR_WIDTH-1:0] wadr_q;
      logic [DATA_WIDTH-1:0] wdat_q;
      logic                  fire;
      logic [8:0]            idx;

      // Both banks use the beat block as word index
      assign idx  = wb_req_i[b].adr[ADDR_WIDTH-1:3];
      // Access completes once the wait has run out and not while acking
      assign fire = wb_req_i[b].cyc & wb_req_i[b].stb & ~ack_q &
                    (wait_q >= delay_i[b]);

      // Every word differs with bank and full index
      initial
      begin
         for (int i = 0; i < 512; i++)
            mem[i] = (32'(b) << 28) ^ (32'(i) * 32'h0001_0203);
      end

      always_ff @(posedge clk_i, negedge rst_ni)
      begin
         if (!rst_ni)
         begin
            ack_q  <= 1'b0;
            wr_q   <= 1'b0;
            wait_q <= '0;
         end
         else
         begin
            ack_q <= fire;
            wr_q  <= fire & wb_req_i[b].we;
            // Wait count restarts for every new cycle
            if (ack_q || !(wb_req_i[b].cyc && wb_req_i[b].stb))
               wait_q <= '0;
            else if (!fire)
               wait_q <= wait_q + 4'd1;
         end
      end

      always_ff @(posedge clk_i)
      begin
         if (fire)
         begin
            rdat_q <= mem[idx];
            wadr_q <= wb_req_i[b].adr;
            wdat_q <= wb_req_i[b].dat;
            if (wb_req_i[b].we)
               mem[idx] <= wb_req_i[b].dat;
         end
      end

      assign wb_rsp_o[b].ack = ack_q;
      assign wb_rsp_o[b].dat = rdat_q;
      assign wr_o[b]         = wr_q;
      assign wr_adr_o[b]     = wadr_q;
      assign wr_dat_o[b]     = wdat_q;
   end

endmodule

// File: verification/tb_tcdm_dma.sv
/*
 * Testbench for the TCDM DMA command path
 *  - Clock, reset, xorshift stimulus and ack delays
 *  - Reference memory with expected bank writes and read beats
 *  - Phases for aligned writes, unaligned reads, back-pressure
 *    and single-beat read-after-write
 */

module tb_tcdm_dma;
   import tcdm_dma_pkg::*;

   localparam int PUSH_TIMEOUT  = 400;
   localparam int DRAIN_TIMEOUT = 5000;

   logic                             clk_i;
   logic                             rst_ni;
   dma_cmd_t                         cmd_i;
   logic                             cmd_req_i;
   logic                             cmd_gnt;
   wb_req_t [1:0]                    wb_req;
   wb_rsp_t [1:0]                    wb_rsp;
   tcdm_rsp_t                        rsp;
   logic                             rsp_valid;

   // Bank model control and write reports
   logic [1:0][3:0]                  delay;
   logic [1:0]                       wr;
   logic [1:0][ADDR_WIDTH-1:0]       wr_adr;
   logic [1:0][DATA_WIDTH-1:0]       wr_dat;

   // Reference state
   logic [31:0]                      rnd;
   logic                             long_delay;
   logic                             saw_full;
   logic [2*DATA_WIDTH-1:0]          ref_mem [512];
   logic [ADDR_WIDTH+DATA_WIDTH-1:0] exp_wr0 [$];
   logic [ADDR_WIDTH+DATA_WIDTH-1:0] exp_wr1 [$];
   tcdm_rsp_t                        exp_rd [$];

   tcdm_dma_top
   #(
      .CMD_QUEUE_DEPTH ( 4 )
   )
   u_tcdm_dma_top
   (
      .clk_i       ( clk_i     ),
      .rst_ni      ( rst_ni    ),
      .cmd_i       ( cmd_i     ),
      .cmd_req_i   ( cmd_req_i ),
      .cmd_gnt_o   ( cmd_gnt   ),
      .wb_req_o    ( wb_req    ),
      .wb_rsp_i    ( wb_rsp    ),
      .rsp_o       ( rsp       ),
      .rsp_valid_o ( rsp_valid )
   );

   tcdm_bank_model u_bank_model
   (
      .clk_i    ( clk_i  ),
      .rst_ni   ( rst_ni ),
      .wb_req_i ( wb_req ),
      .wb_rsp_o ( wb_rsp ),
      .delay_i  ( delay  ),
      .wr_o     ( wr     ),
      .wr_adr_o ( wr_adr ),
      .wr_dat_o ( wr_dat )
   );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   //****************************************
   // Helpers
   //****************************************

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rnd = xorshift(rnd);
      return rnd;
   endfunction

   // Preload pattern of the bank model
   function automatic logic [31:0] start_word(input int bank, input int idx);
      return (32'(bank) << 28) ^ (32'(idx) * 32'h0001_0203);
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                            $time, name, got, exp));
   endtask

   function automatic dma_cmd_t make_cmd(input dma_opc_e opc, input logic [11:0] add,
                                         input logic [14:0] len);
      dma_cmd_t c;
      c.opc  = opc;
      c.add  = add;
      c.len  = len;
      c.sid  = SID_WIDTH'(next_random());
      c.fill = next_random();
      return c;
   endfunction

   // One beat per 8-byte block touched by add..add+len
   task automatic model_cmd(input dma_cmd_t c);
      int         first;
      int         last;
      int         nb;
      logic [8:0] blk;
      tcdm_rsp_t  rs;
      first = int'(c.add) >> 3;
      last  = (int'(c.add) + int'(c.len)) >> 3;
      nb    = last - first + 1;
      for (int k = 0; k < nb; k++)
      begin
         // Beat addresses wrap with the 12-bit TCDM space
         blk = 9'(first + k);
         if (c.opc == DMA_WRITE)
         begin
            ref_mem[blk] = {c.fill, c.fill};
            exp_wr0.push_back({blk, 3'b000, c.fill});
            exp_wr1.push_back({blk, 3'b100, c.fill});
         end
         else
         begin
            rs.data = ref_mem[blk];
            rs.sid  = c.sid;
            rs.eop  = (k == nb - 1);
            exp_rd.push_back(rs);
         end
      end
   endtask

   // One cycle with new ack delays on the falling edge and output checks
   task automatic tick();
      tcdm_rsp_t                        er;
      logic [ADDR_WIDTH+DATA_WIDTH-1:0] ew;
      @(negedge clk_i);
      for (int b = 0; b < 2; b++)
      begin
         if (long_delay)
            delay[b] = 4'(32'd6 + next_random() % 32'd4);
         else
            delay[b] = 4'(next_random() % 32'd4);
         // Open cycle strobes with cyc on all byte lanes
         if (wb_req[b].cyc)
         begin
            check($sformatf("wb_req_o[%0d].stb", b), 64'(wb_req[b].stb), 64'd1);
            check($sformatf("wb_req_o[%0d].sel", b), 64'(wb_req[b].sel), 64'hf);
         end
      end
      if (rst_ni && !cmd_gnt)
         saw_full = 1'b1;
      if (rsp_valid)
      begin
         if (exp_rd.size() == 0)
            fail_run("Read response arrived while no read beat was outstanding");
         er = exp_rd.pop_front();
         check("rsp_o.data", rsp.data, er.data);
         check("rsp_o.sid", 64'(rsp.sid), 64'(er.sid));
         check("rsp_o.eop", 64'(rsp.eop), 64'(er.eop));
      end
      if (wr[0])
      begin
         if (exp_wr0.size() == 0)
            fail_run("Bank 0 was written while no write beat was outstanding");
         ew = exp_wr0.pop_front();
         check("bank 0 write address", 64'(wr_adr[0]), 64'(ew[43:32]));
         check("bank 0 write data", 64'(wr_dat[0]), 64'(ew[31:0]));
      end
      if (wr[1])
      begin
         if (exp_wr1.size() == 0)
            fail_run("Bank 1 was written while no write beat was outstanding");
         ew = exp_wr1.pop_front();
         check("bank 1 write address", 64'(wr_adr[1]), 64'(ew[43:32]));
         check("bank 1 write data", 64'(wr_dat[1]), 64'(ew[31:0]));
      end
   endtask

   task automatic send_cmd(input dma_cmd_t c);
      int waited;
      waited = 0;
      model_cmd(c);
      cmd_i     = c;
      cmd_req_i = 1'b1;
      while (!cmd_gnt)
      begin
         tick();
         waited++;
         if (waited > PUSH_TIMEOUT)
            fail_run("Timeout: the command queue never granted a pushed command");
      end
      // Handshake happens on the next rising edge
      tick();
      cmd_req_i = 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_rd.size() != 0 || exp_wr0.size() != 0 || exp_wr1.size() != 0)
      begin
         tick();
         waited++;
         if (waited > DRAIN_TIMEOUT)
            fail_run("Timeout: outstanding beats never completed on the banks");
      end
   endtask

   //****************************************
   // Test sequence
   //****************************************

   initial
   begin
      logic [11:0] add;
      int          off;
      rst_ni         = 1'b0;
      cmd_i          = '0;
      cmd_req_i      = 1'b0;
      delay          = '0;
      rnd            = 32'h2dcf;
      long_delay     = 1'b0;
      saw_full       = 1'b0;
      for (int i = 0; i < 512; i++)
         ref_mem[i] = {start_word(1, i), start_word(0, i)};

      repeat (8) tick();
      rst_ni = 1'b1;
      tick();

      // Idle outputs after reset
      check("rsp_valid_o", 64'(rsp_valid), 64'd0);
      check("wb_req_o[0].cyc", 64'(wb_req[0].cyc), 64'd0);
      check("wb_req_o[1].cyc", 64'(wb_req[1].cyc), 64'd0);
      check("cmd_gnt_o", 64'(cmd_gnt), 64'd1);

      // Aligned writes of random length
      for (int n = 0; n < 10; n++)
      begin
         add = {9'(next_random()), 3'b000};
         send_cmd(make_cmd(DMA_WRITE, add, 15'(next_random() % 32'd40)));
      end
      drain();

      // Unaligned reads that always cross a block boundary
      for (int n = 0; n < 10; n++)
      begin
         add      = 12'(next_random() % 32'd512);
         add[2:0] = 3'(32'd1 + next_random() % 32'd7);
         send_cmd(make_cmd(DMA_READ, add, 15'(32'd8 + next_random() % 32'd32)));
      end
      drain();

      // Burst under slow banks so the queue fills
      long_delay = 1'b1;
      saw_full   = 1'b0;
      for (int n = 0; n < 12; n++)
      begin
         add = 12'(next_random() % 32'd512);
         if (next_random() % 32'd2 == 32'd0)
            send_cmd(make_cmd(DMA_WRITE, add, 15'(next_random() % 32'd32)));
         else
            send_cmd(make_cmd(DMA_READ, add, 15'(next_random() % 32'd32)));
      end
      drain();
      check("saw_full", 64'(saw_full), 64'd1);
      long_delay = 1'b0;

      // Single-beat write and a read of the same bytes
      for (int n = 0; n < 6; n++)
      begin
         off = int'(next_random() % 32'd8);
         add = {9'(next_random()), 3'(off)};
         send_cmd(make_cmd(DMA_WRITE, add, 15'(next_random() % 32'(8 - off))));
         send_cmd(make_cmd(DMA_READ, add, 15'(next_random() % 32'(8 - off))));
      end
      drain();

      // Trailing cycles would expose extra beats
      repeat (40) tick();

      $display("Test OK");
      $finish;
   end

endmodule

// File: tcdm_dma.f
hdl/tcdm_dma_pkg.sv
hdl/dma_cmd_queue.sv
hdl/tcdm_cmd_unpack.sv
hdl/tcdm_bank_master.sv
hdl/tcdm_rsp_collect.sv
hdl/tcdm_dma_top.sv
verification/tcdm_bank_model.sv
verification/tb_tcdm_dma.sv

// File: run_sim.sh
#!/bin/sh
# Build the TCDM DMA testbench with Verilator and run it
# The simulator exits non-zero on any failing check
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f tcdm_dma.f --top-module tb_tcdm_dma -o tb_tcdm_dma

./obj_dir/tb_tcdm_dma
